// ==== hdl/cache_pkg.sv ====
/*
 * shared types for the dual-port cache subsystem
 * client request, burst command and line geometry
 */

package cache_pkg;

  // client side
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  // all zero strobes mean a read
  typedef logic [3:0] strb_t;

  // burst RAM side, byte addressed
  typedef logic [63:0] beat_t;
  typedef logic [20:0] ram_addr_t;

  // one client request
  typedef struct packed {
    addr_t addr;
    word_t wdata;
    strb_t wstrb;
  } cache_req_t;

  // one burst command, write=1 writes a line and write=0 reads one
  typedef struct packed {
    logic      write;
    ram_addr_t addr;
  } br_cmd_t;

  // a line is 8 words moved as 4 beats of two words each
  localparam int COLUMNS = 8;
  localparam int BEATS = 4;

  // byte offset inside a line
  localparam int OFFSET_BITS = 5;

endpackage

// ==== hdl/line_ram.sv ====
/*
 * line RAM
 * one word per line index, byte write strobes and an asynchronous read
 */

`timescale 1ns/1ns

module line_ram #(
  parameter int addr_bits = 8
) (
  input  logic                 clk,
  input  cache_pkg::strb_t     we,
  input  logic [addr_bits-1:0] addr,
  input  cache_pkg::word_t     wdata,
  output cache_pkg::word_t     rdata
);

  import cache_pkg::*;

  word_t mem [2**addr_bits];

  // each strobe bit writes its own byte lane
  always_ff @(posedge clk) begin
    for (int i = 0; i < $bits(strb_t); i++) begin
      if (we[i]) begin
        mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
      end
    end
  end

  assign rdata = mem[addr];

endmodule

// ==== hdl/cache.sv ====
/*
 * direct-mapped write-back cache
 * serves hits from tag and column RAMs, evicts dirty lines and
 * refills missed lines over a 4-beat burst command port
 */

`timescale 1ns/1ns

module cache #(
  parameter int line_ix_bits = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_valid,
  input  cache_pkg::cache_req_t req,
  output logic                  req_ready,
  output logic                  rsp_valid,
  output cache_pkg::word_t      rsp_data,
  output logic                  cmd_valid,
  output cache_pkg::br_cmd_t    cmd,
  input  logic                  cmd_ready,
  output cache_pkg::beat_t      wr_beat,
  input  logic                  rd_valid,
  input  cache_pkg::beat_t      rd_beat
);

  import cache_pkg::*;

  localparam int col_bits = $clog2(COLUMNS);
  localparam int byte_bits = OFFSET_BITS - col_bits;
  localparam int line_bits = $bits(ram_addr_t) - OFFSET_BITS;
  localparam int tag_bits = line_bits - line_ix_bits;
  localparam int beat_bits = $clog2(BEATS);
  localparam logic [beat_bits-1:0] last_beat = beat_bits'(BEATS - 1);

  typedef enum logic [2:0] {
    idle,
    evict,
    evict_beats,
    fetch_cmd,
    fetch_beats,
    tag_update
  } fill_state_t;

  fill_state_t state;
  logic [beat_bits-1:0] beat;

  // address fields of the request, bits above the RAM range are dropped
  logic [col_bits-1:0] col;
  logic [line_ix_bits-1:0] ix;
  logic [tag_bits-1:0] req_tag;

  assign col = req.addr[byte_bits +: col_bits];
  assign ix = req.addr[OFFSET_BITS +: line_ix_bits];
  assign req_tag = req.addr[OFFSET_BITS + line_ix_bits +: tag_bits];

  // line being filled, captured while idle
  logic [line_bits-1:0] fill_line;
  logic [line_ix_bits-1:0] fill_ix;
  logic [tag_bits-1:0] fill_tag;

  assign fill_ix = fill_line[line_ix_bits-1:0];
  assign fill_tag = fill_line[line_bits-1:line_ix_bits];

  // tag sweep after reset marks every line invalid
  logic clearing;
  logic [line_ix_bits-1:0] clear_ix;

  logic [line_ix_bits-1:0] ram_ix;
  logic [line_ix_bits-1:0] tag_ix;

  assign ram_ix = (state == idle) ? ix : fill_ix;
  assign tag_ix = clearing ? clear_ix : ram_ix;

  // tag word is {dirty, valid, tag} zero extended
  strb_t tag_we;
  word_t tag_wdata;
  word_t tag_rdata;
  logic [tag_bits-1:0] cached_tag;
  logic tag_valid;
  logic tag_dirty;

  assign cached_tag = tag_rdata[tag_bits-1:0];
  assign tag_valid = tag_rdata[tag_bits];
  assign tag_dirty = tag_rdata[tag_bits+1];

  line_ram #(
    .addr_bits(line_ix_bits)
  ) tag_ram (
    .clk  (clk),
    .we   (tag_we),
    .addr (tag_ix),
    .wdata(tag_wdata),
    .rdata(tag_rdata)
  );

  strb_t col_we [COLUMNS];
  word_t col_wdata [COLUMNS];
  word_t col_rdata [COLUMNS];

  for (genvar i = 0; i < COLUMNS; i++) begin : g_col
    line_ram #(
      .addr_bits(line_ix_bits)
    ) col_ram (
      .clk  (clk),
      .we   (col_we[i]),
      .addr (ram_ix),
      .wdata(col_wdata[i]),
      .rdata(col_rdata[i])
    );
  end

  logic tag_hit;
  logic miss;
  logic accept;
  logic is_write;

  assign tag_hit = tag_valid && (cached_tag == req_tag);
  assign req_ready = (state == idle) && !clearing && tag_hit;
  assign miss = (state == idle) && !clearing && req_valid && !tag_hit;
  assign accept = req_valid && req_ready;
  assign is_write = req.wstrb != '0;

  // burst command comes straight from the state, held until accepted
  assign cmd_valid = (state == evict) || (state == fetch_cmd);

  always_comb begin
    cmd.write = (state == evict);
    if (state == evict) begin
      cmd.addr = {cached_tag, fill_ix, OFFSET_BITS'(0)};
    end else begin
      cmd.addr = {fill_line, OFFSET_BITS'(0)};
    end
  end

  // victim line leaves two columns per beat
  assign wr_beat = {col_rdata[{beat, 1'b1}], col_rdata[{beat, 1'b0}]};

  always_comb begin
    for (int i = 0; i < COLUMNS; i++) begin
      col_we[i] = '0;
      col_wdata[i] = req.wdata;
    end
    tag_we = '0;
    tag_wdata = '0;

    if (clearing) begin
      tag_we = '1;
    end else if (state == fetch_beats && rd_valid) begin
      col_we[{beat, 1'b0}] = '1;
      col_wdata[{beat, 1'b0}] = rd_beat[31:0];
      col_we[{beat, 1'b1}] = '1;
      col_wdata[{beat, 1'b1}] = rd_beat[63:32];
    end else if (state == tag_update) begin
      tag_we = '1;
      tag_wdata = word_t'({1'b0, 1'b1, fill_tag});
    end else if (accept && is_write) begin
      // write hit updates the word and marks the line dirty
      col_we[col] = req.wstrb;
      tag_we = '1;
      tag_wdata = word_t'({1'b1, 1'b1, req_tag});
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clearing <= 1'b1;
      clear_ix <= '0;
    end else if (clearing) begin
      clear_ix <= clear_ix + 1'b1;
      if (clear_ix == '1) begin
        clearing <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == idle) begin
      fill_line <= req.addr[$bits(ram_addr_t)-1:OFFSET_BITS];
    end
  end

  // beat wraps to zero at the end of each burst
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
      beat <= '0;
    end else begin
      unique case (state)
        idle: begin
          if (miss) begin
            state <= tag_dirty ? evict : fetch_cmd;
          end
        end
        evict: begin
          // beat 0 went out with the command
          if (cmd_ready) begin
            beat <= beat + 1'b1;
            state <= evict_beats;
          end
        end
        evict_beats: begin
          beat <= beat + 1'b1;
          if (beat == last_beat) begin
            state <= fetch_cmd;
          end
        end
        fetch_cmd: begin
          if (cmd_ready) begin
            state <= fetch_beats;
          end
        end
        fetch_beats: begin
          if (rd_valid) begin
            beat <= beat + 1'b1;
            if (beat == last_beat) begin
              state <= tag_update;
            end
          end
        end
        tag_update: begin
          state <= idle;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // one response per accepted read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= accept && !is_write;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rsp_data <= col_rdata[col];
    end
  end

endmodule

// ==== hdl/burst_arbiter.sv ====
/*
 * burst arbiter
 * shares one burst RAM port between two caches, one transaction at a
 * time, round robin, and keeps the PSRAM command interval
 */

`timescale 1ns/1ns

module burst_arbiter #(
  parameter int cmd_interval = 13
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                a_cmd_valid,
  input  logic                b_cmd_valid,
  input  cache_pkg::br_cmd_t  a_cmd,
  input  cache_pkg::br_cmd_t  b_cmd,
  output logic                a_cmd_ready,
  output logic                b_cmd_ready,
  input  cache_pkg::beat_t    a_wr_beat,
  input  cache_pkg::beat_t    b_wr_beat,
  output logic                a_rd_valid,
  output logic                b_rd_valid,
  output cache_pkg::beat_t    rd_beat,
  output logic                br_cmd_en,
  output logic                br_cmd,
  output cache_pkg::ram_addr_t br_addr,
  output cache_pkg::beat_t    br_wr_data,
  input  cache_pkg::beat_t    br_rd_data,
  input  logic                br_rd_data_valid
);

  import cache_pkg::*;

  localparam int gap_bits = $clog2(cmd_interval + 2);
  localparam int beat_bits = $clog2(BEATS);
  localparam logic [beat_bits-1:0] last_beat = beat_bits'(BEATS - 1);

  typedef enum logic [1:0] {
    idle,
    write_beats,
    wait_read,
    read_beats
  } arb_state_t;

  arb_state_t state;
  logic owner_b;
  logic prefer_b;
  logic [gap_bits-1:0] gap;
  logic [beat_bits-1:0] beat;

  logic open;
  logic pick_b;
  logic accept;
  br_cmd_t cmd_sel;
  beat_t wr_beat_sel;

  // new commands only when idle or for the refill after an eviction
  assign open = (gap == '0) && (state == idle || state == wait_read);

  always_comb begin
    if (state == idle) begin
      pick_b = b_cmd_valid && (!a_cmd_valid || prefer_b);
    end else begin
      pick_b = owner_b;
    end
  end

  // ready only toward a cache that is asking
  assign a_cmd_ready = open && !pick_b && a_cmd_valid;
  assign b_cmd_ready = open && pick_b && b_cmd_valid;
  assign accept = pick_b ? (b_cmd_valid && b_cmd_ready) : (a_cmd_valid && a_cmd_ready);
  assign cmd_sel = pick_b ? b_cmd : a_cmd;
  assign wr_beat_sel = pick_b ? b_wr_beat : a_wr_beat;

  // read beats go to the owner only
  assign rd_beat = br_rd_data;
  assign a_rd_valid = (state == read_beats) && !owner_b && br_rd_data_valid;
  assign b_rd_valid = (state == read_beats) && owner_b && br_rd_data_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
      owner_b <= 1'b0;
      prefer_b <= 1'b0;
      gap <= '0;
      beat <= '0;
      br_cmd_en <= 1'b0;
    end else begin
      br_cmd_en <= accept;
      if (accept) begin
        gap <= gap_bits'(cmd_interval);
      end else if (gap != '0) begin
        gap <= gap - 1'b1;
      end
      unique case (state)
        idle: begin
          if (accept) begin
            owner_b <= pick_b;
            prefer_b <= !pick_b;
            if (cmd_sel.write) begin
              beat <= beat + 1'b1;
              state <= write_beats;
            end else begin
              state <= read_beats;
            end
          end
        end
        write_beats: begin
          beat <= beat + 1'b1;
          if (beat == last_beat) begin
            state <= wait_read;
          end
        end
        wait_read: begin
          if (accept) begin
            state <= read_beats;
          end
        end
        read_beats: begin
          if (br_rd_data_valid) begin
            beat <= beat + 1'b1;
            if (beat == last_beat) begin
              state <= idle;
            end
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // beat 0 lines up with br_cmd_en and the rest follow each cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      br_cmd <= cmd_sel.write;
      br_addr <= cmd_sel.addr;
    end
    br_wr_data <= wr_beat_sel;
  end

endmodule

// ==== hdl/dual_cache_top.sv ====
/*
 * dual-port cache subsystem
 * two write-back caches sharing one burst PSRAM port through an arbiter
 */

`timescale 1ns/1ns

module dual_cache_top #(
  parameter int line_ix_bits = 8,
  parameter int cmd_interval = 13
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  a_req_valid,
  input  cache_pkg::cache_req_t a_req,
  output logic                  a_req_ready,
  output logic                  a_rsp_valid,
  output cache_pkg::word_t      a_rsp_data,
  input  logic                  b_req_valid,
  input  cache_pkg::cache_req_t b_req,
  output logic                  b_req_ready,
  output logic                  b_rsp_valid,
  output cache_pkg::word_t      b_rsp_data,
  output logic                  br_cmd_en,
  output logic                  br_cmd,
  output cache_pkg::ram_addr_t  br_addr,
  output cache_pkg::beat_t      br_wr_data,
  input  cache_pkg::beat_t      br_rd_data,
  input  logic                  br_rd_data_valid
);

  import cache_pkg::*;

  // cache to arbiter links
  logic a_cmd_valid;
  logic a_cmd_ready;
  br_cmd_t a_cmd;
  beat_t a_wr_beat;
  logic a_rd_valid;
  logic b_cmd_valid;
  logic b_cmd_ready;
  br_cmd_t b_cmd;
  beat_t b_wr_beat;
  logic b_rd_valid;
  beat_t rd_beat;

  cache #(
    .line_ix_bits(line_ix_bits)
  ) cache_a (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_valid(a_req_valid),
    .req      (a_req),
    .req_ready(a_req_ready),
    .rsp_valid(a_rsp_valid),
    .rsp_data (a_rsp_data),
    .cmd_valid(a_cmd_valid),
    .cmd      (a_cmd),
    .cmd_ready(a_cmd_ready),
    .wr_beat  (a_wr_beat),
    .rd_valid (a_rd_valid),
    .rd_beat  (rd_beat)
  );

  cache #(
    .line_ix_bits(line_ix_bits)
  ) cache_b (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_valid(b_req_valid),
    .req      (b_req),
    .req_ready(b_req_ready),
    .rsp_valid(b_rsp_valid),
    .rsp_data (b_rsp_data),
    .cmd_valid(b_cmd_valid),
    .cmd      (b_cmd),
    .cmd_ready(b_cmd_ready),
    .wr_beat  (b_wr_beat),
    .rd_valid (b_rd_valid),
    .rd_beat  (rd_beat)
  );

  burst_arbiter #(
    .cmd_interval(cmd_interval)
  ) arbiter (
    .clk             (clk),
    .rst_n           (rst_n),
    .a_cmd_valid     (a_cmd_valid),
    .b_cmd_valid     (b_cmd_valid),
    .a_cmd           (a_cmd),
    .b_cmd           (b_cmd),
    .a_cmd_ready     (a_cmd_ready),
    .b_cmd_ready     (b_cmd_ready),
    .a_wr_beat       (a_wr_beat),
    .b_wr_beat       (b_wr_beat),
    .a_rd_valid      (a_rd_valid),
    .b_rd_valid      (b_rd_valid),
    .rd_beat         (rd_beat),
    .br_cmd_en       (br_cmd_en),
    .br_cmd          (br_cmd),
    .br_addr         (br_addr),
    .br_wr_data      (br_wr_data),
    .br_rd_data      (br_rd_data),
    .br_rd_data_valid(br_rd_data_valid)
  );

endmodule

// ==== verif/psram_model.sv ====
/*
 * behavioral burst PSRAM
 * 4-beat bursts with a fixed read latency, checks the command spacing
 */

`timescale 1ns/1ns

module psram_model #(
  parameter int cmd_interval = 13
) (
  input  logic                 clk,
  input  logic                 br_cmd_en,
  input  logic                 br_cmd,
  input  cache_pkg::ram_addr_t br_addr,
  input  cache_pkg::beat_t     br_wr_data,
  output cache_pkg::beat_t     br_rd_data,
  output logic                 br_rd_data_valid,
  output int                   spacing_errors
);

  import cache_pkg::*;

  localparam int read_latency = 6;

  logic [7:0] mem [int];
  int since;
  int wr_left;
  int wr_addr;
  int rd_count;
  int rd_addr;

  // bytes never written hold a pattern of their address
  function automatic logic [7:0] init_byte(input int a);
    return 8'(a ^ (a >> 8) ^ (a >> 16)) ^ 8'h5a;
  endfunction

  function automatic beat_t load_beat(input int a);
    beat_t b;
    for (int i = 0; i < 8; i++) begin
      b[i*8 +: 8] = mem.exists(a + i) ? mem[a + i] : init_byte(a + i);
    end
    return b;
  endfunction

  task automatic store_beat(input int a, input beat_t b);
    for (int i = 0; i < 8; i++) begin
      mem[a + i] = b[i*8 +: 8];
    end
  endtask

  initial begin
    br_rd_data = '0;
    br_rd_data_valid = 1'b0;
    spacing_errors = 0;
    since = 1 << 20;
    wr_left = 0;
    rd_count = 0;
  end

  always @(posedge clk) begin
    // read beats leave on consecutive cycles once the latency is over
    br_rd_data_valid <= 1'b0;
    if (rd_count >= read_latency - 1) begin
      br_rd_data_valid <= 1'b1;
      br_rd_data <= load_beat(rd_addr + 8 * (rd_count - read_latency + 1));
    end
    if (rd_count == read_latency + BEATS - 2) begin
      rd_count = 0;
    end else if (rd_count > 0) begin
      rd_count++;
    end
    // write beats 1 to 3 follow the command cycle
    if (wr_left > 0) begin
      store_beat(wr_addr, br_wr_data);
      wr_addr += 8;
      wr_left--;
    end
    since++;
    if (br_cmd_en) begin
      assert (since > cmd_interval) else begin
        spacing_errors++;
        $display("psram commands came %0d cycles apart, the minimum is %0d",
                 since, cmd_interval + 1);
      end
      since = 0;
      if (br_cmd) begin
        store_beat(br_addr, br_wr_data);
        wr_addr = br_addr + 8;
        wr_left = BEATS - 1;
      end else begin
        rd_addr = br_addr;
        rd_count = 1;
      end
    end
  end

endmodule

// ==== verif/tb_dual_cache.sv ====
/*
 * testbench for the dual-port cache subsystem
 * random reads and writes on both ports, checked against a byte reference memory
 */

`timescale 1ns/1ns

module tb_dual_cache;

  import cache_pkg::*;

  localparam int line_ix_bits = 4;
  localparam int cmd_interval = 13;
  localparam int accesses = 300;
  localparam int timeout_cycles = 400;

  logic clk;
  logic rst_n;
  logic [1:0] req_valid;
  cache_req_t [1:0] req;
  logic [1:0] req_ready;
  logic [1:0] rsp_valid;
  word_t [1:0] rsp_data;
  logic br_cmd_en;
  logic br_cmd;
  ram_addr_t br_addr;
  beat_t br_wr_data;
  beat_t br_rd_data;
  logic br_rd_data_valid;
  int spacing_errors;

  int checks;
  int errors;
  logic [7:0] ref_mem [int];
  logic rsp_due [2];
  word_t rsp_exp [2];
  string rsp_name [2];
  logic [15:0] first_line [2];
  logic cmd_seen [2];

  dual_cache_top #(
    .line_ix_bits(line_ix_bits),
    .cmd_interval(cmd_interval)
  ) UUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .a_req_valid     (req_valid[0]),
    .a_req           (req[0]),
    .a_req_ready     (req_ready[0]),
    .a_rsp_valid     (rsp_valid[0]),
    .a_rsp_data      (rsp_data[0]),
    .b_req_valid     (req_valid[1]),
    .b_req           (req[1]),
    .b_req_ready     (req_ready[1]),
    .b_rsp_valid     (rsp_valid[1]),
    .b_rsp_data      (rsp_data[1]),
    .br_cmd_en       (br_cmd_en),
    .br_cmd          (br_cmd),
    .br_addr         (br_addr),
    .br_wr_data      (br_wr_data),
    .br_rd_data      (br_rd_data),
    .br_rd_data_valid(br_rd_data_valid)
  );

  psram_model #(
    .cmd_interval(cmd_interval)
  ) ram (
    .clk             (clk),
    .br_cmd_en       (br_cmd_en),
    .br_cmd          (br_cmd),
    .br_addr         (br_addr),
    .br_wr_data      (br_wr_data),
    .br_rd_data      (br_rd_data),
    .br_rd_data_valid(br_rd_data_valid),
    .spacing_errors  (spacing_errors)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // unwritten RAM bytes start as a pattern of their address
  function automatic logic [7:0] initial_byte(input int a);
    return 8'(a ^ (a >> 8) ^ (a >> 16)) ^ 8'h5a;
  endfunction

  function automatic word_t ref_word(input ram_addr_t ra);
    word_t w;
    int base;
    base = int'({ra[20:2], 2'b00});
    for (int i = 0; i < 4; i++) begin
      w[i*8 +: 8] = ref_mem.exists(base + i) ? ref_mem[base + i] : initial_byte(base + i);
    end
    return w;
  endfunction

  function automatic string port_name(input int p);
    return (p == 0) ? "a" : "b";
  endfunction

  // own half of RAM, four tags over four indices so lines conflict often
  function automatic ram_addr_t pick_addr(input int p);
    int tag;
    int ix;
    int col;
    tag = $urandom % 4;
    ix = $urandom % 4;
    col = $urandom % 8;
    return ram_addr_t'((p << 20) | (tag << 13) | (ix << 5) | (col << 2));
  endfunction

  // one clock edge of port p, checking the response expected at it
  task automatic step(input int p);
    @(posedge clk);
    if (rsp_due[p]) begin
      checks++;
      assert (rsp_valid[p] === 1'b1) else begin
        errors++;
        $display("port %s gave no response one cycle after a read", port_name(p));
      end
      assert (rsp_data[p] === rsp_exp[p]) else begin
        errors++;
        $display("error %s port %s: expected %h, actual %h",
                 rsp_name[p], port_name(p), rsp_exp[p], rsp_data[p]);
      end
    end else begin
      assert (rsp_valid[p] === 1'b0) else begin
        errors++;
        $display("port %s gave a response with no read pending", port_name(p));
      end
    end
    rsp_due[p] = 1'b0;
  endtask

  task automatic idle_cycle(input int p);
    step(p);
    #1;
  endtask

  task automatic access(input int p, input ram_addr_t ra, input strb_t strb,
                        input string name, output bit ok);
    int waited;
    int base;
    word_t wd;
    wd = $urandom;
    base = int'({ra[20:2], 2'b00});
    // noise above bit 20 must not matter
    req[p] = '{addr: {11'($urandom), ra}, wdata: wd, wstrb: strb};
    req_valid[p] = 1'b1;
    ok = 1'b0;
    waited = 0;
    while (!ok && waited < timeout_cycles) begin
      step(p);
      ok = req_ready[p];
      waited++;
    end
    assert (ok) else begin
      errors++;
      $display("port %s request for %h was not accepted within %0d cycles",
               port_name(p), ra, timeout_cycles);
    end
    if (ok && strb != '0) begin
      for (int i = 0; i < 4; i++) begin
        if (strb[i]) begin
          ref_mem[base + i] = wd[i*8 +: 8];
        end
      end
    end else if (ok) begin
      rsp_due[p] = 1'b1;
      rsp_exp[p] = ref_word(ra);
      rsp_name[p] = name;
    end
    #1;
    req_valid[p] = 1'b0;
  endtask

  task automatic run_port(input int p);
    ram_addr_t ra;
    ram_addr_t home;
    strb_t strb;
    bit ok;
    // dirty line displaced by another tag at the same index, then read back
    home = ram_addr_t'((p << 20) | (3 << 5) | (5 << 2));
    first_line[p] = home[20:5];
    access(p, home, 4'hf, "eviction write", ok);
    if (ok) begin
      access(p, home | ram_addr_t'(1 << 13), '0, "eviction displace", ok);
    end
    if (ok) begin
      access(p, home, '0, "eviction read back", ok);
    end
    for (int n = 0; n < accesses && ok; n++) begin
      ra = pick_addr(p);
      if ($urandom % 2 == 0) begin
        strb = '0;
      end else begin
        strb = strb_t'($urandom % 15 + 1);
      end
      access(p, ra, strb, "random access", ok);
      repeat ($urandom % 3) begin
        idle_cycle(p);
      end
    end
    idle_cycle(p);
  endtask

  // first burst command of each half fetches the first line it touched
  always @(posedge clk) begin
    if (br_cmd_en === 1'b1 && !cmd_seen[br_addr[20]]) begin
      cmd_seen[br_addr[20]] = 1'b1;
      checks++;
      assert ({br_cmd, br_addr} === {1'b0, first_line[br_addr[20]], 5'b0}) else begin
        errors++;
        $display("error first command port %s: expected %h, actual %h",
                 port_name(br_addr[20]), {1'b0, first_line[br_addr[20]], 5'b0},
                 {br_cmd, br_addr});
      end
    end
  end

  initial begin
    void'($urandom(32'hf379));
    rst_n = 1'b0;
    req_valid = '0;
    req = '0;
    checks = 0;
    errors = 0;
    for (int p = 0; p < 2; p++) begin
      rsp_due[p] = 1'b0;
      cmd_seen[p] = 1'b0;
      first_line[p] = '0;
    end
    repeat (2) begin
      @(posedge clk);
    end
    #1;
    rst_n = 1'b1;
    checks++;
    assert (br_cmd_en === 1'b0 && rsp_valid === 2'b00) else begin
      errors++;
      $display("br_cmd_en or rsp_valid is not low after reset");
    end
    // both ports start together so their first misses collide
    fork
      run_port(0);
      run_port(1);
    join
    $display("checks %0d, errors %0d, psram spacing errors %0d",
             checks, errors, spacing_errors);
    if (errors == 0 && spacing_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== dual_cache.f ====
hdl/cache_pkg.sv
hdl/line_ram.sv
hdl/cache.sv
hdl/burst_arbiter.sv
hdl/dual_cache_top.sv
verif/psram_model.sv
verif/tb_dual_cache.sv

// ==== Bender.yml ====
package:
  name: dual_cache

dependencies: {}

sources:
  # design
  - files:
      - hdl/cache_pkg.sv
      - hdl/line_ram.sv
      - hdl/cache.sv
      - hdl/burst_arbiter.sv
      - hdl/dual_cache_top.sv

  # testbench
  - target: test
    files:
      - verif/psram_model.sv
      - verif/tb_dual_cache.sv
